// ==== include/box_overlay_defines.svh ====
`ifndef BOX_OVERLAY_DEFINES_SVH
`define BOX_OVERLAY_DEFINES_SVH

// Field widths
`define COORD_W     10
`define PIX_W       8

// Box table size
`define BOX_COUNT   16
`define BOX_ADDR_W  4

// Default frame size
`define DEF_HDISP   640
`define DEF_VDISP   480

// Outline colour, pure red
`define MARK_RED    255
`define MARK_GREEN  0
`define MARK_BLUE   0

`endif

// ==== design/box_overlay_pkg.sv ====
`include "box_overlay_defines.svh"

package box_overlay_pkg;

    typedef struct packed {
        logic [`PIX_W-1:0] red;
        logic [`PIX_W-1:0] green;
        logic [`PIX_W-1:0] blue;
    } rgb_t;

    // One 27-bit pixel clock of the stream
    typedef struct packed {
        logic vsync;
        logic href;
        logic clken;
        rgb_t pixel;
    } video_beat_t;

    // 41-bit box word with valid on top
    typedef struct packed {
        logic               valid;   // bit 40
        logic [`COORD_W-1:0] y_max;
        logic [`COORD_W-1:0] x_max;
        logic [`COORD_W-1:0] y_min;
        logic [`COORD_W-1:0] x_min;  // bits 9:0
    } box_rect_t;

    typedef struct packed {
        logic [`COORD_W-1:0] x;
        logic [`COORD_W-1:0] y;
    } pixel_pos_t;

endpackage

// ==== design/pixel_position.sv ====
`timescale 1ns/1ps
`include "box_overlay_defines.svh"

module pixel_position
#(
    parameter int H_DISP = `DEF_HDISP,
    parameter int V_DISP = `DEF_VDISP
)
(
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  box_overlay_pkg::video_beat_t beat,
    output box_overlay_pkg::pixel_pos_t  pos,
    output logic                         armed
);
    import box_overlay_pkg::*;

    localparam logic [`COORD_W-1:0] X_LAST = `COORD_W'(H_DISP - 1);
    localparam logic [`COORD_W-1:0] Y_END  = `COORD_W'(V_DISP);

    pixel_pos_t pos_nxt;

    always_comb
    begin
        pos_nxt = pos;
        if (!beat.vsync)
        begin
            pos_nxt = '0;   // Blanking clears both counters
        end
        else if (beat.clken)
        begin
            if (pos.x == X_LAST)
            begin
                pos_nxt.x = '0;
                pos_nxt.y = pos.y + 1'b1;
            end
            else
            begin
                pos_nxt.x = pos.x + 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            pos <= '0;
        else
            pos <= pos_nxt;
    end

    // Full frame counted and vsync dropped, sticky until reset
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            armed <= 1'b0;
        else if (!beat.vsync && pos.y == Y_END && pos.x == '0)
            armed <= 1'b1;
    end

endmodule

// ==== design/box_table.sv ====
`timescale 1ns/1ps
`include "box_overlay_defines.svh"

module box_table
(
    input  logic                       sys_clk,
    input  logic                       sys_rst_n,
    input  logic                       cfg_req,
    input  logic [`BOX_ADDR_W-1:0]     cfg_addr,
    input  box_overlay_pkg::box_rect_t cfg_data,
    output logic                       cfg_ack,
    output box_overlay_pkg::box_rect_t boxes [`BOX_COUNT]
);
    import box_overlay_pkg::*;

    box_rect_t slots [`BOX_COUNT];
    logic      wr_en;

    // New request seen while ack still low
    assign wr_en = cfg_req && !cfg_ack;

    // Ack follows req one clock later, which gives the four phases
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
            cfg_ack <= 1'b0;
        else
            cfg_ack <= cfg_req;
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            for (int i = 0; i < `BOX_COUNT; i++)
            begin
                slots[i] <= '0;   // All slots start disabled
            end
        end
        else if (wr_en)
        begin
            slots[cfg_addr] <= cfg_data;
        end
    end

    // Table contents go out in parallel to the comparators
    always_comb
    begin
        for (int i = 0; i < `BOX_COUNT; i++)
        begin
            boxes[i] = slots[i];
        end
    end

endmodule

// ==== design/box_edge_detect.sv ====
`timescale 1ns/1ps
`include "box_overlay_defines.svh"

module box_edge_detect
(
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  box_overlay_pkg::video_beat_t beat,
    input  box_overlay_pkg::pixel_pos_t  pos,
    input  box_overlay_pkg::box_rect_t   boxes [`BOX_COUNT],
    output box_overlay_pkg::video_beat_t beat_d,
    output logic                         hit
);
    import box_overlay_pkg::*;

    logic hit_c;

    // Outline test per box, corners excluded
    always_comb
    begin
        box_rect_t b;
        logic      in_x;
        logic      in_y;
        logic      on_row;
        logic      on_col;

        hit_c = 1'b0;
        for (int i = 0; i < `BOX_COUNT; i++)
        begin
            b      = boxes[i];
            in_x   = (pos.x > b.x_min) && (pos.x < b.x_max);
            in_y   = (pos.y > b.y_min) && (pos.y < b.y_max);
            on_row = (pos.y == b.y_min) || (pos.y == b.y_max);
            on_col = (pos.x == b.x_min) || (pos.x == b.x_max);
            if (b.valid && ((in_x && on_row) || (in_y && on_col)))
            begin
                hit_c = 1'b1;   // Any box will do, all share one colour
            end
        end
    end

    // First pipeline stage
    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            beat_d <= '0;
            hit    <= 1'b0;
        end
        else
        begin
            beat_d <= beat;
            hit    <= hit_c;
        end
    end

endmodule

// ==== design/overlay_mixer.sv ====
`timescale 1ns/1ps
`include "box_overlay_defines.svh"

module overlay_mixer
(
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  box_overlay_pkg::video_beat_t beat_d,
    input  logic                         hit,
    input  logic                         armed,
    output box_overlay_pkg::video_beat_t post
);
    import box_overlay_pkg::*;

    localparam rgb_t MARK = '{
        red:   `PIX_W'(`MARK_RED),
        green: `PIX_W'(`MARK_GREEN),
        blue:  `PIX_W'(`MARK_BLUE)
    };

    always_ff @(posedge sys_clk or negedge sys_rst_n)
    begin
        if (!sys_rst_n)
        begin
            post <= '0;
        end
        else
        begin
            // Downstream sees no sync until a whole frame has gone by
            post.vsync <= armed && beat_d.vsync;
            post.href  <= armed && beat_d.href;
            post.clken <= armed && beat_d.clken;
            if (armed && hit)
                post.pixel <= MARK;
            else
                post.pixel <= beat_d.pixel;   // Pixels always flow
        end
    end

endmodule

// ==== design/box_overlay_top.sv ====
`timescale 1ns/1ps
`include "box_overlay_defines.svh"

module box_overlay_top
#(
    parameter int H_DISP = `DEF_HDISP,
    parameter int V_DISP = `DEF_VDISP
)
(
    input  logic                         sys_clk,
    input  logic                         sys_rst_n,
    input  box_overlay_pkg::video_beat_t per,
    input  logic                         cfg_req,
    input  logic [`BOX_ADDR_W-1:0]       cfg_addr,
    input  box_overlay_pkg::box_rect_t   cfg_data,
    output logic                         cfg_ack,
    output box_overlay_pkg::video_beat_t post
);

    box_overlay_pkg::pixel_pos_t  pos;
    box_overlay_pkg::box_rect_t   boxes [`BOX_COUNT];
    box_overlay_pkg::video_beat_t beat_d;
    logic                         armed;
    logic                         hit;

    pixel_position
    #(
        .H_DISP (H_DISP),
        .V_DISP (V_DISP)
    )
    u_pixel_position
    (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .beat      (per),
        .pos       (pos),
        .armed     (armed)
    );

    box_table u_box_table
    (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cfg_req   (cfg_req),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .cfg_ack   (cfg_ack),
        .boxes     (boxes)
    );

    // Stage 1
    box_edge_detect u_box_edge_detect
    (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .beat      (per),
        .pos       (pos),
        .boxes     (boxes),
        .beat_d    (beat_d),
        .hit       (hit)
    );

    // Stage 2
    overlay_mixer u_overlay_mixer
    (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .beat_d    (beat_d),
        .hit       (hit),
        .armed     (armed),
        .post      (post)
    );

endmodule

// ==== bench/box_overlay_tb.sv ====
`timescale 1ns/1ps
`include "box_overlay_defines.svh"

module box_overlay_tb;
    import box_overlay_pkg::*;

    localparam int H_DISP     = 64;
    localparam int V_DISP     = 48;
    localparam int H_BLANK    = 10;
    localparam int HS_TIMEOUT = 32;   // Clocks per handshake phase

    localparam rgb_t MARK_RGB = '{
        red:   `PIX_W'(`MARK_RED),
        green: `PIX_W'(`MARK_GREEN),
        blue:  `PIX_W'(`MARK_BLUE)
    };

    logic                   sys_clk;
    logic                   sys_rst_n;
    video_beat_t            per;
    logic                   cfg_req;
    logic [`BOX_ADDR_W-1:0] cfg_addr;
    box_rect_t              cfg_data;
    logic                   cfg_ack;
    video_beat_t            post;

    integer seed = 32'h7edd8879;

    // Reference model state
    box_rect_t   m_boxes [`BOX_COUNT];
    int          m_x;
    int          m_y;
    logic        m_armed;
    logic        m_ack;
    video_beat_t exp_d1;
    video_beat_t exp_d2;   // Lines up with post
    int          n_marks;
    int          n_masked;
    int          n_gaps;

    box_overlay_top
    #(
        .H_DISP (H_DISP),
        .V_DISP (V_DISP)
    )
    uut
    (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .per       (per),
        .cfg_req   (cfg_req),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .cfg_ack   (cfg_ack),
        .post      (post)
    );

    initial
    begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic box_rect_t make_box(input logic valid, input int x0, input int y0,
                                           input int x1, input int y1);
        box_rect_t b;
        b.valid = valid;
        b.x_min = `COORD_W'(x0);
        b.y_min = `COORD_W'(y0);
        b.x_max = `COORD_W'(x1);
        b.y_max = `COORD_W'(y1);
        return b;
    endfunction

    // Outline of any enabled box without its corners
    function automatic logic outline_hit(input int x, input int y);
        logic found;
        found = 1'b0;
        for (int i = 0; i < `BOX_COUNT; i++)
        begin
            if (m_boxes[i].valid)
            begin
                if ((y == m_boxes[i].y_min || y == m_boxes[i].y_max) &&
                    x > m_boxes[i].x_min && x < m_boxes[i].x_max)
                    found = 1'b1;   // Top or bottom row
                if ((x == m_boxes[i].x_min || x == m_boxes[i].x_max) &&
                    y > m_boxes[i].y_min && y < m_boxes[i].y_max)
                    found = 1'b1;   // Left or right column
            end
        end
        return found;
    endfunction

    // Expected output computed per input beat, then delayed two clocks
    always @(posedge sys_clk or negedge sys_rst_n)
    begin
        logic        armed_now;
        logic        hit_now;
        video_beat_t e;

        if (!sys_rst_n)
        begin
            for (int i = 0; i < `BOX_COUNT; i++)
                m_boxes[i] <= '0;
            m_x      <= 0;
            m_y      <= 0;
            m_armed  <= 1'b0;
            m_ack    <= 1'b0;
            exp_d1   <= '0;
            exp_d2   <= '0;
            n_marks  <= 0;
            n_masked <= 0;
        end
        else
        begin
            armed_now = m_armed || (!per.vsync && m_y == V_DISP && m_x == 0);
            hit_now   = outline_hit(m_x, m_y);
            e.vsync   = armed_now && per.vsync;
            e.href    = armed_now && per.href;
            e.clken   = armed_now && per.clken;
            e.pixel   = (armed_now && hit_now) ? MARK_RGB : per.pixel;
            exp_d1  <= e;
            exp_d2  <= exp_d1;
            m_armed <= armed_now;
            if (armed_now && hit_now)
                n_marks <= n_marks + 1;
            if (!armed_now && hit_now)
                n_masked <= n_masked + 1;   // Edge present but not yet armed

            if (!per.vsync)
            begin
                m_x <= 0;
                m_y <= 0;
            end
            else if (per.clken)
            begin
                if (m_x == H_DISP - 1)
                begin
                    m_x <= 0;
                    m_y <= m_y + 1;
                end
                else
                begin
                    m_x <= m_x + 1;
                end
            end

            // Slot written once, as ack rises
            if (cfg_req && !m_ack)
                m_boxes[cfg_addr] <= cfg_data;
            m_ack <= cfg_req;
        end
    end

    a_ack: assert property (@(posedge sys_clk) disable iff (!sys_rst_n) cfg_ack == m_ack)
        else fail_now($sformatf("ERR cfg_ack expected %h got %h",
                                $sampled(m_ack), $sampled(cfg_ack)));

    a_sync: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                             {post.vsync, post.href, post.clken} ==
                             {exp_d2.vsync, exp_d2.href, exp_d2.clken})
        else fail_now($sformatf("ERR post sync expected %h got %h",
                                $sampled({exp_d2.vsync, exp_d2.href, exp_d2.clken}),
                                $sampled({post.vsync, post.href, post.clken})));

    a_pixel: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
                              post.pixel == exp_d2.pixel)
        else fail_now($sformatf("ERR post.pixel expected %h got %h",
                                $sampled(exp_d2.pixel), $sampled(post.pixel)));

    task automatic drive_beat(input logic vs, input logic hr, input logic ce);
        logic [31:0] r;
        @(negedge sys_clk);
        r         = $random(seed);
        per.vsync = vs;
        per.href  = hr;
        per.clken = ce;
        per.pixel = r[23:0];
    endtask

    task automatic blank_lines(input int cycles);
        repeat (cycles) drive_beat(1'b0, 1'b0, 1'b0);
    endtask

    // Four-phase write while video sits in blanking
    task automatic write_box(input logic [`BOX_ADDR_W-1:0] slot, input box_rect_t data);
        int n;
        @(negedge sys_clk);
        cfg_addr = slot;
        cfg_data = data;
        cfg_req  = 1'b1;
        n = 0;
        while (cfg_ack !== 1'b1 && n < HS_TIMEOUT)
        begin
            @(negedge sys_clk);
            n++;
        end
        if (cfg_ack !== 1'b1)
            fail_now("Timeout: cfg_ack never rose after cfg_req was raised");
        cfg_req = 1'b0;
        n = 0;
        while (cfg_ack !== 1'b0 && n < HS_TIMEOUT)
        begin
            @(negedge sys_clk);
            n++;
        end
        if (cfg_ack !== 1'b0)
            fail_now("Timeout: cfg_ack never fell after cfg_req was dropped");
    endtask

    task automatic drive_line(input bit gaps);
        int x;
        for (int i = 0; i < H_BLANK; i++)
            drive_beat(1'b1, 1'b0, 1'b0);
        x = 0;
        while (x < H_DISP)
        begin
            if (gaps && (($random(seed) & 3) == 0))
            begin
                drive_beat(1'b1, 1'b1, 1'b0);   // Stall so position holds
                n_gaps++;
            end
            else
            begin
                drive_beat(1'b1, 1'b1, 1'b1);
                x++;
            end
        end
    endtask

    task automatic drive_frame(input bit gaps);
        for (int y = 0; y < V_DISP; y++)
            drive_line(gaps);
        repeat (H_BLANK) drive_beat(1'b1, 1'b0, 1'b0);
    endtask

    initial
    begin
        sys_rst_n = 1'b0;
        per.vsync = 1'b1;   // Busy inputs must not leak through reset
        per.href  = 1'b1;
        per.clken = 1'b1;
        per.pixel = 24'h5ac396;
        cfg_req   = 1'b1;
        cfg_addr  = '0;
        cfg_data  = make_box(1'b1, 1, 1, 9, 9);
        n_gaps    = 0;
        repeat (4) @(posedge sys_clk);
        @(negedge sys_clk);

        assert (cfg_ack === 1'b0)
            else fail_now($sformatf("ERR cfg_ack expected 0 got %h", cfg_ack));
        assert (post === '0)
            else fail_now($sformatf("ERR post expected %h got %h", 27'h0, post));
        sys_rst_n = 1'b1;
        per       = '0;
        cfg_req   = 1'b0;
        cfg_data  = '0;

        blank_lines(4);
        write_box(4'd0,  make_box(1'b1, 5, 4, 20, 15));
        write_box(4'd1,  make_box(1'b1, 30, 10, 50, 30));
        write_box(4'd2,  make_box(1'b0, 2, 30, 12, 40));   // Disabled slot
        write_box(4'd3,  make_box(1'b1, 10, 20, 25, 44));
        write_box(4'd5,  make_box(1'b1, 40, 2, 60, 8));
        write_box(4'd7,  make_box(1'b1, 0, 0, 63, 47));    // Frame border
        write_box(4'd9,  make_box(1'b1, 33, 35, 37, 38));
        write_box(4'd15, make_box(1'b1, 50, 40, 51, 41));  // No pixel strictly inside
        blank_lines(4);

        drive_frame(1'b0);   // Not armed yet
        blank_lines(6);
        drive_frame(1'b0);
        blank_lines(3);

        // Move slot 0 while vsync is low
        write_box(4'd0, make_box(1'b1, 12, 26, 30, 42));
        blank_lines(3);
        drive_frame(1'b1);
        blank_lines(8);

        if (n_marks == 0 || n_masked == 0 || n_gaps == 0)
            fail_now("Stimulus never reached a marked pixel, a masked edge or a clken gap");
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== box_overlay.f ====
+incdir+include
design/box_overlay_pkg.sv
design/pixel_position.sv
design/box_table.sv
design/box_edge_detect.sv
design/overlay_mixer.sv
design/box_overlay_top.sv
bench/box_overlay_tb.sv
